//--- source/ex_defs.svh
/*
 * Width and iteration constants of the execute unit.
 * Included by the packages and modules that size their buses from it.
 */

`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// data path and register file address
`define DATA_W      32
`define REG_ADDR_W  5

// one quotient bit per divider step
`define DIV_STEPS   32

`define SHAMT_W     5

`endif

//--- source/ex_ops_pkg.sv
/*
 * Operation codes understood by the execute unit.
 * The issuing stage fills ex_issue_t.op with one of these.
 */

`default_nettype none

package ex_ops_pkg;

    typedef enum logic [4:0] {
        NOP,
        ADD, SUB,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLLV, SRLV, SRAV,
        MULT, MULTU,
        DIV, DIVU,
        MFHI, MFLO
    } alu_op_e;

endpackage

`default_nettype wire

//--- source/ex_pipe_pkg.sv
/*
 * Records passed between the issuing stage, the execute logic and EX/MEM.
 */

`default_nettype none

`include "ex_defs.svh"

package ex_pipe_pkg;

    typedef struct packed {
        logic                    valid;
        ex_ops_pkg::alu_op_e     op;
        logic [`DATA_W-1:0]      oprand1;
        logic [`DATA_W-1:0]      oprand2;
        logic [`REG_ADDR_W-1:0]  waddr;
        logic                    we;
    } ex_issue_t;

    typedef struct packed {
        logic                en;
        logic [`DATA_W-1:0]  hi;
        logic [`DATA_W-1:0]  lo;
    } hilo_write_t;

    typedef struct packed {
        logic                    valid;
        logic                    we;
        logic [`REG_ADDR_W-1:0]  waddr;
        logic [`DATA_W-1:0]      result;
        hilo_write_t             hilo;
    } ex_result_t;

endpackage

`default_nettype wire

//--- source/ex_alu.sv
/*
 * Combinational execute logic. Decodes the issued operation, produces the
 * register result or HI/LO write, and drives the divider for div/divu.
 */

`timescale 1ns/1ns
`default_nettype none

`include "ex_defs.svh"

module ex_alu (
    input  ex_pipe_pkg::ex_issue_t    issue_i,
    input  logic [`DATA_W-1:0]        hi_i,
    input  logic [`DATA_W-1:0]        lo_i,
    input  logic [2*`DATA_W-1:0]      div_result_i,
    input  logic                      div_done_i,
    output logic                      div_start_o,
    output logic                      div_signed_o,
    output logic [`DATA_W-1:0]        dividend_o,
    output logic [`DATA_W-1:0]        divisor_o,
    output logic                      div_pause_o,
    output ex_pipe_pkg::ex_result_t   result_o
);

    logic [`DATA_W-1:0]    a;
    logic [`DATA_W-1:0]    b;
    logic [`SHAMT_W-1:0]   shamt;
    logic [2*`DATA_W-1:0]  prod_s;
    logic [2*`DATA_W-1:0]  prod_u;
    logic                  lt_s;
    logic                  lt_u;
    logic                  is_div;

    assign a     = issue_i.oprand1;
    assign b     = issue_i.oprand2;
    assign shamt = a[`SHAMT_W-1:0];

    // low half of the extended product is the signed product
    assign prod_s = {{`DATA_W{a[`DATA_W-1]}}, a} * {{`DATA_W{b[`DATA_W-1]}}, b};
    assign prod_u = {{`DATA_W{1'b0}}, a} * {{`DATA_W{1'b0}}, b};

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    assign is_div = issue_i.valid &&
                    (issue_i.op == ex_ops_pkg::DIV || issue_i.op == ex_ops_pkg::DIVU);

    // divider only samples start while idle
    assign div_start_o  = is_div;
    assign div_signed_o = (issue_i.op == ex_ops_pkg::DIV);
    assign dividend_o   = a;
    assign divisor_o    = b;
    assign div_pause_o  = is_div && !div_done_i;

    always_comb begin
        result_o.valid  = issue_i.valid;
        result_o.we     = issue_i.we;
        result_o.waddr  = issue_i.waddr;
        result_o.result = '0;
        result_o.hilo   = '0;
        case (issue_i.op)
            ex_ops_pkg::ADD:  result_o.result = a + b;
            ex_ops_pkg::SUB:  result_o.result = a - b;
            ex_ops_pkg::AND:  result_o.result = a & b;
            ex_ops_pkg::OR:   result_o.result = a | b;
            ex_ops_pkg::XOR:  result_o.result = a ^ b;
            ex_ops_pkg::NOR:  result_o.result = ~(a | b);
            ex_ops_pkg::SLT:  result_o.result = {{(`DATA_W-1){1'b0}}, lt_s};
            ex_ops_pkg::SLTU: result_o.result = {{(`DATA_W-1){1'b0}}, lt_u};
            ex_ops_pkg::SLLV: result_o.result = b << shamt;
            ex_ops_pkg::SRLV: result_o.result = b >> shamt;
            ex_ops_pkg::SRAV: result_o.result = $unsigned($signed(b) >>> shamt);
            ex_ops_pkg::MULT: begin
                result_o.we      = 1'b0;
                result_o.hilo.en = 1'b1;
                result_o.hilo.hi = prod_s[2*`DATA_W-1:`DATA_W];
                result_o.hilo.lo = prod_s[`DATA_W-1:0];
            end
            ex_ops_pkg::MULTU: begin
                result_o.we      = 1'b0;
                result_o.hilo.en = 1'b1;
                result_o.hilo.hi = prod_u[2*`DATA_W-1:`DATA_W];
                result_o.hilo.lo = prod_u[`DATA_W-1:0];
            end
            ex_ops_pkg::DIV, ex_ops_pkg::DIVU: begin
                // remainder to HI, quotient to LO
                result_o.we      = 1'b0;
                result_o.hilo.en = 1'b1;
                result_o.hilo.hi = div_result_i[2*`DATA_W-1:`DATA_W];
                result_o.hilo.lo = div_result_i[`DATA_W-1:0];
            end
            ex_ops_pkg::MFHI: result_o.result = hi_i;
            ex_ops_pkg::MFLO: result_o.result = lo_i;
            default:          result_o.result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/div_unit.sv
/*
 * Iterative restoring divider, one quotient bit per cycle on magnitudes,
 * sign-corrected at the end. The result stays valid until acknowledged.
 */

`timescale 1ns/1ns
`default_nettype none

`include "ex_defs.svh"

module div_unit (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      start_i,
    input  logic                      signed_i,
    input  logic [`DATA_W-1:0]        dividend_i,
    input  logic [`DATA_W-1:0]        divisor_i,
    input  logic                      ack_i,
    output logic [2*`DATA_W-1:0]      result_o,
    output logic                      done_o
);

    localparam int CNT_W = $clog2(`DIV_STEPS);

    typedef enum logic [1:0] {S_IDLE, S_BUSY, S_DONE} div_state_e;

    div_state_e          state;
    logic [CNT_W-1:0]    count;
    logic                last_step;
    logic [`DATA_W-1:0]  rem_q;
    logic [`DATA_W-1:0]  quo_q;
    logic [`DATA_W-1:0]  dvs_q;
    logic                neg_quo;
    logic                neg_rem;
    logic [`DATA_W-1:0]  dividend_abs;
    logic [`DATA_W-1:0]  divisor_abs;
    logic [`DATA_W:0]    shifted;
    logic [`DATA_W:0]    diff;
    logic [`DATA_W-1:0]  rem_nxt;
    logic [`DATA_W-1:0]  quo_nxt;

    assign dividend_abs = (signed_i && dividend_i[`DATA_W-1]) ? -dividend_i : dividend_i;
    assign divisor_abs  = (signed_i && divisor_i[`DATA_W-1]) ? -divisor_i : divisor_i;

    // keep the old partial remainder when the trial subtract goes negative
    assign shifted = {rem_q, quo_q[`DATA_W-1]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign rem_nxt = diff[`DATA_W] ? shifted[`DATA_W-1:0] : diff[`DATA_W-1:0];
    assign quo_nxt = {quo_q[`DATA_W-2:0], ~diff[`DATA_W]};

    assign last_step = (count == CNT_W'(`DIV_STEPS - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= S_IDLE;
            count <= '0;
        end else begin
            case (state)
                S_IDLE: if (start_i) begin
                    state <= S_BUSY;
                    count <= '0;
                end
                S_BUSY: begin
                    count <= count + 1'b1;
                    if (last_step)
                        state <= S_DONE;
                end
                default: if (ack_i)
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start_i) begin
            rem_q   <= '0;
            quo_q   <= dividend_abs;
            dvs_q   <= divisor_abs;
            neg_quo <= signed_i && (dividend_i[`DATA_W-1] ^ divisor_i[`DATA_W-1]);
            neg_rem <= signed_i && dividend_i[`DATA_W-1];
        end else if (state == S_BUSY) begin
            rem_q <= rem_nxt;
            quo_q <= quo_nxt;
            if (last_step)
                result_o <= {neg_rem ? -rem_nxt : rem_nxt, neg_quo ? -quo_nxt : quo_nxt};
        end
    end

    assign done_o = (state == S_DONE);

endmodule

`default_nettype wire

//--- source/hilo_regs.sv
/*
 * HI/LO register pair. Written from the retiring EX/MEM entry; reads see
 * that pending write so mfhi/mflo can follow mult directly.
 */

`timescale 1ns/1ns
`default_nettype none

`include "ex_defs.svh"

module hilo_regs (
    input  logic                       clk,
    input  logic                       rst_i,
    input  ex_pipe_pkg::hilo_write_t   write_i,
    input  logic                       stall_i,
    output logic [`DATA_W-1:0]         hi_o,
    output logic [`DATA_W-1:0]         lo_o
);

    logic [`DATA_W-1:0] hi_q;
    logic [`DATA_W-1:0] lo_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (write_i.en && !stall_i) begin
            hi_q <= write_i.hi;
            lo_q <= write_i.lo;
        end
    end

    // bypass of the write still sitting in EX/MEM
    assign hi_o = write_i.en ? write_i.hi : hi_q;
    assign lo_o = write_i.en ? write_i.lo : lo_q;

endmodule

`default_nettype wire

//--- source/ex_mem_reg.sv
/*
 * EX/MEM pipeline register. Combines the divider and memory pause requests,
 * holds while memory stalls and inserts a bubble when nothing is accepted.
 */

`timescale 1ns/1ns
`default_nettype none

`include "ex_defs.svh"

module ex_mem_reg (
    input  logic                       clk,
    input  logic                       rst_i,
    input  ex_pipe_pkg::ex_result_t    result_i,
    input  logic                       issue_valid_i,
    input  logic                       div_pause_i,
    input  logic                       mem_stall_i,
    output ex_pipe_pkg::ex_result_t    ex_mem_o,
    output logic                       pause_o,
    output logic                       accept_o
);

    assign pause_o  = div_pause_i || mem_stall_i;
    assign accept_o = issue_valid_i && !pause_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_mem_o.valid   <= 1'b0;
            ex_mem_o.we      <= 1'b0;
            ex_mem_o.hilo.en <= 1'b0;
        end else if (!mem_stall_i) begin
            ex_mem_o <= result_i;
            // bubble keeps the payload but drops every enable
            if (!accept_o) begin
                ex_mem_o.valid   <= 1'b0;
                ex_mem_o.we      <= 1'b0;
                ex_mem_o.hilo.en <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ex_unit.sv
/*
 * Execute unit top level: ALU, divider, HI/LO pair and EX/MEM register.
 * The driver holds issue_i while pause_o is high.
 */

`timescale 1ns/1ns
`default_nettype none

`include "ex_defs.svh"

module ex_unit (
    input  logic                       clk,
    input  logic                       rst_i,
    input  ex_pipe_pkg::ex_issue_t     issue_i,
    input  logic                       mem_stall_i,
    output ex_pipe_pkg::ex_result_t    ex_mem_o,
    output logic                       pause_o
);

    ex_pipe_pkg::ex_result_t  alu_result;
    logic [`DATA_W-1:0]       hi_data;
    logic [`DATA_W-1:0]       lo_data;
    logic [2*`DATA_W-1:0]     div_result;
    logic                     div_done;
    logic                     div_start;
    logic                     div_signed;
    logic [`DATA_W-1:0]       dividend;
    logic [`DATA_W-1:0]       divisor;
    logic                     div_pause;
    logic                     accept;

    ex_alu alu0 (
        .issue_i      (issue_i),
        .hi_i         (hi_data),
        .lo_i         (lo_data),
        .div_result_i (div_result),
        .div_done_i   (div_done),
        .div_start_o  (div_start),
        .div_signed_o (div_signed),
        .dividend_o   (dividend),
        .divisor_o    (divisor),
        .div_pause_o  (div_pause),
        .result_o     (alu_result)
    );

    div_unit div0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .dividend_i (dividend),
        .divisor_i  (divisor),
        .ack_i      (accept),
        .result_o   (div_result),
        .done_o     (div_done)
    );

    hilo_regs hilo0 (
        .clk     (clk),
        .rst_i   (rst_i),
        .write_i (ex_mem_o.hilo),
        .stall_i (mem_stall_i),
        .hi_o    (hi_data),
        .lo_o    (lo_data)
    );

    ex_mem_reg ex_mem0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .result_i      (alu_result),
        .issue_valid_i (issue_i.valid),
        .div_pause_i   (div_pause),
        .mem_stall_i   (mem_stall_i),
        .ex_mem_o      (ex_mem_o),
        .pause_o       (pause_o),
        .accept_o      (accept)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
/*
 * Free-running 8 ns clock for the testbench, with a synchronous reset
 * held high over the first three rising edges.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // release away from the rising edge
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/ex_unit_properties.sv
/*
 * Concurrent checks on the execute unit top level. Bound into ex_unit by
 * the testbench; fail_count is read back at the end of the run.
 */

`timescale 1ns/1ns
`default_nettype none

module ex_unit_properties (
    input  logic                       clk,
    input  logic                       rst_i,
    input  ex_pipe_pkg::ex_issue_t     issue_i,
    input  logic                       mem_stall_i,
    input  ex_pipe_pkg::ex_result_t    ex_mem_o,
    input  logic                       pause_o,
    input  logic                       div_pause_i
);

    int unsigned fail_count = 0;

    reset_clears: assert property (@(posedge clk)
        rst_i |=> !ex_mem_o.valid && !ex_mem_o.we && !ex_mem_o.hilo.en)
    else begin
        fail_count++;
        $error("ex_mem_o enables not cleared by reset");
    end

    // accepted issue retires on the next cycle with its own address
    one_cycle_latency: assert property (@(posedge clk) disable iff (rst_i)
        (issue_i.valid && !pause_o) |=>
            ex_mem_o.valid && (ex_mem_o.waddr == $past(issue_i.waddr)))
    else begin
        fail_count++;
        $error("accepted issue did not reach ex_mem_o one cycle later");
    end

    stall_holds: assert property (@(posedge clk) disable iff (rst_i)
        mem_stall_i |=> $stable(ex_mem_o))
    else begin
        fail_count++;
        $error("ex_mem_o changed during a memory stall");
    end

    divide_bubbles: assert property (@(posedge clk) disable iff (rst_i)
        (div_pause_i && !mem_stall_i) |=> !ex_mem_o.valid && !ex_mem_o.hilo.en)
    else begin
        fail_count++;
        $error("no bubble loaded while the divider pauses");
    end

endmodule

`default_nettype wire

//--- bench/ex_unit_tb.sv
/*
 * Testbench for the execute unit. Issues random ALU, multiply and divide
 * operations, with and without memory stalls, and checks every retiring
 * entry on ex_mem_o against a reference model in issue order.
 */

`timescale 1ns/1ns
`default_nettype none

`include "ex_defs.svh"

module ex_unit_tb;

    localparam int TIMEOUT = 50;

    logic                     clk;
    logic                     rst_i;
    ex_pipe_pkg::ex_issue_t   issue_i;
    logic                     mem_stall_i;
    ex_pipe_pkg::ex_result_t  ex_mem_o;
    logic                     pause_o;

    ex_pipe_pkg::ex_result_t  expect_q[$];
    ex_pipe_pkg::ex_result_t  held;
    logic [`DATA_W-1:0]       model_hi;
    logic [`DATA_W-1:0]       model_lo;
    logic [31:0]              lcg_state;
    logic                     pop_pending;
    logic                     hold_pending;
    logic                     watch_bubbles;
    int                       checks;
    int                       errors;

    tb_clock clock_gen (
        .clk_o (clk),
        .rst_o (rst_i)
    );

    ex_unit UUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .issue_i     (issue_i),
        .mem_stall_i (mem_stall_i),
        .ex_mem_o    (ex_mem_o),
        .pause_o     (pause_o)
    );

    bind ex_unit ex_unit_properties props (
        .clk         (clk),
        .rst_i       (rst_i),
        .issue_i     (issue_i),
        .mem_stall_i (mem_stall_i),
        .ex_mem_o    (ex_mem_o),
        .pause_o     (pause_o),
        .div_pause_i (div_pause)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    // HI/LO reads come from the model state in issue order
    function automatic ex_pipe_pkg::ex_result_t reference_result(ex_pipe_pkg::ex_issue_t iss);
        ex_pipe_pkg::ex_result_t r;
        logic [4:0]  sh;
        longint      sa;
        longint      sb;
        logic [63:0] wide;
        r = '0;
        r.valid = 1'b1;
        r.we = iss.we;
        r.waddr = iss.waddr;
        sh = iss.oprand1[4:0];
        sa = longint'($signed(iss.oprand1));
        sb = longint'($signed(iss.oprand2));
        wide = '0;
        case (iss.op)
            ex_ops_pkg::ADD:  r.result = iss.oprand1 + iss.oprand2;
            ex_ops_pkg::SUB:  r.result = iss.oprand1 - iss.oprand2;
            ex_ops_pkg::AND:  r.result = iss.oprand1 & iss.oprand2;
            ex_ops_pkg::OR:   r.result = iss.oprand1 | iss.oprand2;
            ex_ops_pkg::XOR:  r.result = iss.oprand1 ^ iss.oprand2;
            ex_ops_pkg::NOR:  r.result = ~(iss.oprand1 | iss.oprand2);
            ex_ops_pkg::SLT:  r.result = (sa < sb) ? 32'd1 : 32'd0;
            ex_ops_pkg::SLTU: r.result = (iss.oprand1 < iss.oprand2) ? 32'd1 : 32'd0;
            ex_ops_pkg::SLLV: r.result = iss.oprand2 << sh;
            ex_ops_pkg::SRLV: r.result = iss.oprand2 >> sh;
            ex_ops_pkg::SRAV: r.result = 32'(sb >>> sh);
            ex_ops_pkg::MULT: wide = sa * sb;
            ex_ops_pkg::MULTU: wide = {32'd0, iss.oprand1} * {32'd0, iss.oprand2};
            ex_ops_pkg::DIV:  wide = {32'(sa % sb), 32'(sa / sb)};
            ex_ops_pkg::DIVU: wide = {iss.oprand1 % iss.oprand2, iss.oprand1 / iss.oprand2};
            ex_ops_pkg::MFHI: r.result = model_hi;
            ex_ops_pkg::MFLO: r.result = model_lo;
            default:          r.result = '0;
        endcase
        if (iss.op inside {ex_ops_pkg::MULT, ex_ops_pkg::MULTU,
                           ex_ops_pkg::DIV, ex_ops_pkg::DIVU}) begin
            r.we = 1'b0;
            r.hilo.en = 1'b1;
            r.hilo.hi = wide[63:32];
            r.hilo.lo = wide[31:0];
        end
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_condition(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic check_retiring();
        ex_pipe_pkg::ex_result_t exp;
        if (expect_q.size() == 0) begin
            check_condition(1'b0, "valid result on ex_mem_o with nothing outstanding");
        end else begin
            exp = expect_q[0];
            compare_value("ex_mem_o.we", ex_mem_o.we, exp.we);
            compare_value("ex_mem_o.waddr", ex_mem_o.waddr, exp.waddr);
            compare_value("ex_mem_o.result", ex_mem_o.result, exp.result);
            compare_value("ex_mem_o.hilo.en", ex_mem_o.hilo.en, exp.hilo.en);
            if (exp.hilo.en) begin
                compare_value("ex_mem_o.hilo.hi", ex_mem_o.hilo.hi, exp.hilo.hi);
                compare_value("ex_mem_o.hilo.lo", ex_mem_o.hilo.lo, exp.hilo.lo);
            end
        end
    endtask

    // check what EX/MEM shows at the falling edge, then drive the next inputs
    task automatic next_cycle(input ex_pipe_pkg::ex_issue_t iss, input logic stall,
                              output logic accepted);
        ex_pipe_pkg::ex_result_t r;
        @(negedge clk);
        if (pop_pending && expect_q.size() > 0)
            expect_q.delete(0);
        if (ex_mem_o.valid)
            check_retiring();
        if (hold_pending)
            check_condition(ex_mem_o === held, "ex_mem_o changed during a memory stall");
        held = ex_mem_o;
        issue_i = iss;
        mem_stall_i = stall;
        pop_pending = ex_mem_o.valid && !stall;
        hold_pending = stall;
        #1;
        if (stall)
            check_condition(pause_o, "pause_o stayed low during a memory stall");
        if (watch_bubbles && pause_o)
            check_condition(!ex_mem_o.valid, "valid result on ex_mem_o during a divide");
        accepted = iss.valid && !pause_o;
        if (accepted) begin
            r = reference_result(iss);
            if (r.hilo.en) begin
                model_hi = r.hilo.hi;
                model_lo = r.hilo.lo;
            end
            expect_q.push_back(r);
        end
    endtask

    // holds the issue until accepted; bit n of stall_pat is the stall in cycle n
    task automatic issue_op(input ex_ops_pkg::alu_op_e op, input logic [31:0] a,
                            input logic [31:0] b, input logic [63:0] stall_pat,
                            output int paused);
        ex_pipe_pkg::ex_issue_t iss;
        logic [31:0] tag;
        logic accepted;
        int n;
        tag = lcg_next();
        iss.valid = 1'b1;
        iss.op = op;
        iss.oprand1 = a;
        iss.oprand2 = b;
        iss.waddr = tag[4:0];
        iss.we = tag[5];
        paused = 0;
        accepted = 1'b0;
        n = 0;
        while (!accepted && n < TIMEOUT) begin
            next_cycle(iss, stall_pat[n], accepted);
            if (!accepted)
                paused++;
            n++;
        end
        if (!accepted)
            check_condition(1'b0, "timeout waiting for pause_o to fall");
    endtask

    task automatic idle_cycles(input int count);
        logic accepted;
        for (int i = 0; i < count; i++)
            next_cycle('0, 1'b0, accepted);
    endtask

    task automatic drain_results();
        logic accepted;
        int n;
        n = 0;
        while (expect_q.size() > 0 && n < TIMEOUT) begin
            next_cycle('0, 1'b0, accepted);
            n++;
        end
        if (expect_q.size() != 0)
            check_condition(1'b0, "timeout waiting for results to retire");
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errors_before);
    endtask

    initial begin
        ex_ops_pkg::alu_op_e alu_ops [11];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        int mark;
        int paused;
        int n;
        issue_i = '0;
        mem_stall_i = 1'b0;
        model_hi = '0;
        model_lo = '0;
        lcg_state = 32'd77;
        pop_pending = 1'b0;
        hold_pending = 1'b0;
        watch_bubbles = 1'b0;
        held = '0;
        checks = 0;
        errors = 0;
        alu_ops = '{ex_ops_pkg::ADD, ex_ops_pkg::SUB, ex_ops_pkg::AND, ex_ops_pkg::OR,
                    ex_ops_pkg::XOR, ex_ops_pkg::NOR, ex_ops_pkg::SLT, ex_ops_pkg::SLTU,
                    ex_ops_pkg::SLLV, ex_ops_pkg::SRLV, ex_ops_pkg::SRAV};

        mark = errors;
        @(posedge clk);
        n = 0;
        while (rst_i && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        check_condition(!rst_i, "timeout waiting for reset release");
        @(negedge clk);
        check_condition(!pause_o, "pause_o high after reset");
        check_condition(!ex_mem_o.valid, "ex_mem_o.valid high after reset");
        finish_test("reset", mark);

        mark = errors;
        for (int i = 0; i < 40; i++) begin
            r = lcg_next();
            a = lcg_next();
            b = lcg_next();
            issue_op(alu_ops[r % 11], a, b, '0, paused);
        end
        drain_results();
        finish_test("random alu", mark);

        // mfhi/mflo straight after the product see the forwarded HI/LO
        mark = errors;
        for (int i = 0; i < 4; i++) begin
            a = lcg_next();
            b = lcg_next();
            issue_op(i[0] ? ex_ops_pkg::MULTU : ex_ops_pkg::MULT, a, b, '0, paused);
            issue_op(ex_ops_pkg::MFHI, '0, '0, '0, paused);
            issue_op(ex_ops_pkg::MFLO, '0, '0, '0, paused);
        end
        drain_results();
        finish_test("multiply and forwarding", mark);

        mark = errors;
        watch_bubbles = 1'b1;
        for (int i = 0; i < 6; i++) begin
            a = lcg_next();
            b = lcg_next();
            r = lcg_next();
            b = b >> (r % 32);
            if (b == 0)
                b = 32'd1;
            idle_cycles(1);
            issue_op(i[0] ? ex_ops_pkg::DIVU : ex_ops_pkg::DIV, a, b, '0, paused);
            compare_value("pause_o cycles", paused, `DIV_STEPS + 1);
            issue_op(ex_ops_pkg::MFLO, '0, '0, '0, paused);
            issue_op(ex_ops_pkg::MFHI, '0, '0, '0, paused);
        end
        drain_results();
        watch_bubbles = 1'b0;
        finish_test("divide", mark);

        // stalls hold a plain result, then overlap both ends of a divide
        mark = errors;
        issue_op(ex_ops_pkg::ADD, lcg_next(), lcg_next(), '0, paused);
        issue_op(ex_ops_pkg::SUB, lcg_next(), lcg_next(), 64'hF, paused);
        a = lcg_next();
        b = lcg_next() >> 9;
        if (b == 0)
            b = 32'd3;
        issue_op(ex_ops_pkg::DIV, a, b, 64'h0000_001F_8000_0007, paused);
        issue_op(ex_ops_pkg::MFLO, '0, '0, '0, paused);
        issue_op(ex_ops_pkg::MFHI, '0, '0, '0, paused);
        issue_op(ex_ops_pkg::OR, lcg_next(), lcg_next(), 64'h3, paused);
        drain_results();
        finish_test("memory stall", mark);

        $display("%0d checks, %0d bench errors, %0d assertion failures",
                 checks, errors, UUT.props.fail_count);
        if (errors == 0 && UUT.props.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+source
source/ex_ops_pkg.sv
source/ex_pipe_pkg.sv
source/ex_alu.sv
source/div_unit.sv
source/hilo_regs.sv
source/ex_mem_reg.sv
source/ex_unit.sv
bench/tb_clock.sv
bench/ex_unit_properties.sv
bench/ex_unit_tb.sv

//--- Bender.yml
package:
  name: ex_unit

sources:
  - include_dirs:
      - source
    files:
      - source/ex_ops_pkg.sv
      - source/ex_pipe_pkg.sv
      - source/ex_alu.sv
      - source/div_unit.sv
      - source/hilo_regs.sv
      - source/ex_mem_reg.sv
      - source/ex_unit.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - bench/tb_clock.sv
      - bench/ex_unit_properties.sv
      - bench/ex_unit_tb.sv
